/* common/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

//////////////////////////////
// address and data widths
//////////////////////////////
`define MEM_ADDR_W    12   // byte address, 4 KB array
`define MEM_WORD_AW   10   // word address inside the array
`define MEM_DATA_W    32   // one bus word
`define MEM_SEL_W     4    // byte selects per word

//////////////////////////////
// burst and fifo sizing
//////////////////////////////
`define MEM_BLEN_W    6    // burst length field, holds length minus one
`define MEM_RD_BURST  8    // words fetched per read miss
`define MEM_INV_TIME  63   // idle clocks before read-ahead goes stale

`define MEM_WR_DEPTH  64   // write data fifo
`define MEM_RD_DEPTH  32   // read data fifo
`define MEM_CMD_DEPTH 4    // burst command fifo

`endif

/* common/mem_pkg.sv */
`include "mem_params.svh"

package mem_pkg;

   //////////////////////////////
   // burst commands
   //////////////////////////////

   // opcodes as seen by the memory port
   typedef enum logic [2:0] {
      MEM_OP_WR_PRE = 3'b010,   // write with auto precharge
      MEM_OP_RD_PRE = 3'b011    // read with auto precharge
   } mem_op_e;

   // one burst, length is stored minus one
   typedef struct packed {
      mem_op_e                op;     // read or write
      logic [`MEM_BLEN_W-1:0] blen;   // words in burst minus one
      logic [`MEM_ADDR_W-1:0] addr;   // first byte address
   } mem_cmd_t;

   //////////////////////////////
   // buffered write word
   //////////////////////////////
   typedef struct packed {
      logic [`MEM_DATA_W-1:0] data;   // write payload
      logic [`MEM_SEL_W-1:0]  sel;    // byte enables, high = write
   } mem_wr_word_t;

endpackage

/* verilog/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
   parameter type payload_t = logic [31:0],   // stored entry
   parameter int  DEPTH     = 16              // entries
) (
   input  logic     wb_clk,
   input  logic     mem_rst,
   input  logic     push_i,        // write one entry
   input  payload_t push_data_i,
   output logic     full_o,
   input  logic     pop_i,         // drop head entry
   output payload_t pop_data_o,    // head entry, valid while not empty
   output logic     empty_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         store [DEPTH];   // circular buffer
   logic [PTR_W-1:0] wr_ptr;          // next free slot
   logic [PTR_W-1:0] rd_ptr;          // head slot
   logic [CNT_W-1:0] count;           // entries held
   logic             do_push;
   logic             do_pop;

   // advance a pointer with wrap at DEPTH
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full_o     = (count == CNT_W'(DEPTH));
   assign empty_o    = (count == '0);
   assign do_push    = push_i & ~full_o;    // push into full fifo is lost
   assign do_pop     = pop_i & ~empty_o;    // pop of empty fifo does nothing
   assign pop_data_o = store[rd_ptr];       // show-ahead

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= ptr_inc(wr_ptr);
         if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
         if (do_push & ~do_pop)
            count <= count + 1'b1;
         else if (do_pop & ~do_push)
            count <= count - 1'b1;   // simultaneous push and pop keep the count
      end
   end

   // storage
   always_ff @(posedge wb_clk) begin
      if (do_push) store[wr_ptr] <= push_data_i;
   end

endmodule

/* wb_port/wb_port_ctrl.sv */
`timescale 1ns/100ps
`include "mem_params.svh"

module wb_port_ctrl (
   input  logic                   wb_clk,
   input  logic                   mem_rst,
   // wishbone, pipelined block transfers
   input  logic                   wbm_cyc_i,
   input  logic                   wbm_stb_i,
   input  logic                   wbm_we_i,
   input  logic [`MEM_SEL_W-1:0]  wbm_sel_i,
   input  logic [`MEM_ADDR_W-1:0] wbm_addr_i,   // byte address
   input  logic [`MEM_DATA_W-1:0] wbm_dat_i,
   output logic                   wbm_ack_o,
   output logic                   wbm_stall_o,
   output logic [`MEM_DATA_W-1:0] wbm_dat_o,
   // memory port
   output logic                   cmd_push_o,
   output mem_pkg::mem_cmd_t      cmd_o,
   input  logic                   cmd_full_i,
   output logic                   wr_push_o,
   output mem_pkg::mem_wr_word_t  wr_word_o,
   input  logic                   wr_full_i,
   output logic                   rd_pop_o,
   input  logic [`MEM_DATA_W-1:0] rd_data_i,    // show-ahead head word
   input  logic                   rd_empty_i
);

   localparam int ADDR_W = `MEM_ADDR_W;
   localparam int BLEN_W = `MEM_BLEN_W;
   localparam int CNT_W  = $clog2(`MEM_WR_DEPTH) + 1;   // holds a full write fifo
   localparam int INV_W  = $clog2(`MEM_INV_TIME + 1);
   localparam logic [INV_W-1:0]  INV_LOAD = INV_W'(`MEM_INV_TIME);
   localparam logic [BLEN_W-1:0] RD_BLEN  = BLEN_W'(`MEM_RD_BURST - 1);

   typedef enum logic [2:0] {
      ST_RST, ST_IDLE, ST_WR_FIFO, ST_WR_CMD, ST_RD_FIFO, ST_RD_CMD
   } state_e;

   state_e             state;
   logic [CNT_W-1:0]   stb_cnt;     // strobes accepted in this cycle
   logic [CNT_W-1:0]   ack_cnt;     // read acks given in this cycle
   logic [ADDR_W-1:0]  adr_beg;     // start of next burst
   logic [ADDR_W-1:0]  adr_next;    // address of read fifo head word
   logic               rd_active;   // read burst issued, no data yet
   logic [INV_W-1:0]   inv_cnt;     // read-ahead lifetime
   mem_pkg::mem_op_e   cmd_op;
   logic [BLEN_W-1:0]  cmd_blen;
   logic               stb_ok;      // strobe taken this clock
   logic               cmd_block;   // no room for a command, counting one in flight
   logic               pend;        // read strobe still waiting for data
   logic               inv_zero;
   logic               hit;         // read-ahead holds the requested word
   logic               take;        // hand read fifo head to the bus

   assign wbm_stall_o = wr_full_i | cmd_full_i;
   assign stb_ok      = wbm_cyc_i & wbm_stb_i & ~wbm_stall_o;
   assign cmd_block   = cmd_full_i | cmd_push_o;
   assign pend        = (ack_cnt != stb_cnt) | stb_ok;
   assign inv_zero    = (inv_cnt == '0);
   assign hit         = (wbm_addr_i == adr_next) & ~rd_empty_i & ~inv_zero;

   // writes go straight into the write fifo
   assign wr_push_o = stb_ok & wbm_we_i;
   assign wr_word_o = '{data: wbm_dat_i, sel: wbm_sel_i};
   assign cmd_o     = '{op: cmd_op, blen: cmd_blen, addr: adr_beg};

   always_comb begin
      case (state)
         ST_IDLE:    take = stb_ok & ~wbm_we_i & hit;
         ST_RD_FIFO: take = wbm_cyc_i & pend & ~rd_active & ~rd_empty_i & ~inv_zero;
         default:    take = 1'b0;
      endcase
   end

   // stale words leave the fifo once the lifetime is over
   assign rd_pop_o = take | (inv_zero & ~rd_empty_i);

   //////////////////////////////
   // main state machine
   //////////////////////////////
   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         state      <= ST_RST;
         wbm_ack_o  <= 1'b0;
         cmd_push_o <= 1'b0;
         rd_active  <= 1'b0;
         inv_cnt    <= '0;
         stb_cnt    <= '0;
         ack_cnt    <= '0;
      end else begin
         wbm_ack_o  <= wr_push_o;   // write ack one clock after the strobe
         cmd_push_o <= 1'b0;
         if (stb_ok) stb_cnt <= stb_cnt + 1'b1;
         if (~rd_empty_i) rd_active <= 1'b0;               // first burst word is in
         if (~inv_zero & ~rd_active) inv_cnt <= inv_cnt - 1'b1;
         case (state)
            ST_RST: begin
               if (~wbm_cyc_i) state <= ST_IDLE;   // let a running cycle finish
            end
            ST_IDLE: begin
               stb_cnt <= CNT_W'(stb_ok);
               ack_cnt <= CNT_W'(take);
               if (stb_ok) begin
                  adr_beg <= wbm_addr_i;
                  if (wbm_we_i) begin
                     inv_cnt <= '0;   // any write kills the read-ahead
                     state   <= ST_WR_FIFO;
                  end else if (take) begin
                     state <= ST_RD_FIFO;
                  end else begin
                     // miss, fetch a new burst from here
                     cmd_op   <= mem_pkg::MEM_OP_RD_PRE;
                     cmd_blen <= RD_BLEN;
                     adr_next <= wbm_addr_i;
                     if (cmd_block | ~rd_empty_i) begin
                        inv_cnt <= '0;   // drain leftovers first
                        state   <= ST_RD_CMD;
                     end else begin
                        cmd_push_o <= 1'b1;
                        rd_active  <= 1'b1;
                        inv_cnt    <= INV_LOAD;
                        state      <= ST_RD_FIFO;
                     end
                  end
               end
            end
            ST_WR_FIFO: begin
               if (wr_full_i | ~wbm_cyc_i) begin
                  cmd_op   <= mem_pkg::MEM_OP_WR_PRE;
                  cmd_blen <= BLEN_W'(stb_cnt - 1'b1);
                  if (cmd_block) begin
                     state <= ST_WR_CMD;
                  end else begin
                     cmd_push_o <= 1'b1;
                     state      <= ST_IDLE;
                  end
               end
            end
            ST_WR_CMD: begin
               if (~cmd_block) begin
                  cmd_push_o <= 1'b1;
                  state      <= ST_IDLE;
               end
            end
            ST_RD_FIFO: begin
               if (wbm_cyc_i & pend & ~rd_active) begin
                  if (take) begin
                     ack_cnt <= ack_cnt + 1'b1;
                  end else if (rd_empty_i) begin
                     // ran out of read-ahead, continue with next burst
                     cmd_op   <= mem_pkg::MEM_OP_RD_PRE;
                     cmd_blen <= RD_BLEN;
                     adr_beg  <= adr_next;
                     inv_cnt  <= INV_LOAD;
                     if (cmd_block) begin
                        state <= ST_RD_CMD;
                     end else begin
                        cmd_push_o <= 1'b1;
                        rd_active  <= 1'b1;
                     end
                  end   // else stale words are still draining
               end else if (~wbm_cyc_i) begin
                  state <= ST_IDLE;
               end
            end
            ST_RD_CMD: begin
               if (~cmd_block & rd_empty_i) begin
                  inv_cnt    <= INV_LOAD;
                  cmd_push_o <= 1'b1;   // command prepared on entry
                  rd_active  <= 1'b1;
                  state      <= ST_RD_FIFO;
               end
            end
            default: state <= ST_RST;
         endcase
         if (take) begin
            wbm_ack_o <= 1'b1;
            wbm_dat_o <= rd_data_i;
            adr_next  <= adr_next + ADDR_W'(4);   // one word further
            inv_cnt   <= INV_LOAD;
         end
      end
   end

endmodule

/* mem_port/mem_port.sv */
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_port (
   input  logic                   wb_clk,
   input  logic                   mem_rst,
   input  logic                   cmd_push_i,
   input  mem_pkg::mem_cmd_t      cmd_i,
   output logic                   cmd_full_o,
   input  logic                   wr_push_i,
   input  mem_pkg::mem_wr_word_t  wr_word_i,
   output logic                   wr_full_o,
   input  logic                   rd_pop_i,
   output logic [`MEM_DATA_W-1:0] rd_data_o,
   output logic                   rd_empty_o
);

   localparam int WORD_AW = `MEM_WORD_AW;
   localparam int BLEN_W  = `MEM_BLEN_W;
   localparam int SEL_W   = `MEM_SEL_W;

   mem_pkg::mem_cmd_t     cmd_head;   // oldest pending command
   logic                  cmd_empty;
   logic                  cmd_pop;
   mem_pkg::mem_wr_word_t wr_head;    // oldest write word
   logic                  wr_empty;
   logic                  wr_pop;
   logic                  rd_full;
   logic                  rd_push;
   logic                  step;       // one burst word done

   logic [`MEM_DATA_W-1:0] mem_arr [2 ** WORD_AW];   // on-chip memory
   logic                   busy;       // burst in progress
   logic                   is_rd;      // current burst direction
   logic [WORD_AW-1:0]     word_adr;   // current word, wraps inside the array
   logic [BLEN_W-1:0]      remain;     // words left after this one

   //////////////////////////////
   // fifos
   //////////////////////////////
   sync_fifo #(.payload_t(mem_pkg::mem_cmd_t), .DEPTH(`MEM_CMD_DEPTH)) cmd_fifo_i (
      .wb_clk(wb_clk), .mem_rst(mem_rst),
      .push_i(cmd_push_i), .push_data_i(cmd_i), .full_o(cmd_full_o),
      .pop_i(cmd_pop), .pop_data_o(cmd_head), .empty_o(cmd_empty)
   );

   sync_fifo #(.payload_t(mem_pkg::mem_wr_word_t), .DEPTH(`MEM_WR_DEPTH)) wr_fifo_i (
      .wb_clk(wb_clk), .mem_rst(mem_rst),
      .push_i(wr_push_i), .push_data_i(wr_word_i), .full_o(wr_full_o),
      .pop_i(wr_pop), .pop_data_o(wr_head), .empty_o(wr_empty)
   );

   sync_fifo #(.payload_t(logic [`MEM_DATA_W-1:0]), .DEPTH(`MEM_RD_DEPTH)) rd_fifo_i (
      .wb_clk(wb_clk), .mem_rst(mem_rst),
      .push_i(rd_push), .push_data_i(mem_arr[word_adr]), .full_o(rd_full),
      .pop_i(rd_pop_i), .pop_data_o(rd_data_o), .empty_o(rd_empty_o)
   );

   //////////////////////////////
   // burst engine
   //////////////////////////////
   assign cmd_pop = ~busy & ~cmd_empty;            // take next command when idle
   assign wr_pop  = busy & ~is_rd & ~wr_empty;     // wait for write data
   assign rd_push = busy & is_rd & ~rd_full;       // back-pressure from read fifo
   assign step    = wr_pop | rd_push;

   always_ff @(posedge wb_clk) begin
      if (mem_rst)
         busy <= 1'b0;
      else if (cmd_pop)
         busy <= 1'b1;
      else if (step & (remain == '0))
         busy <= 1'b0;   // last word of the burst
   end

   // burst address and length
   always_ff @(posedge wb_clk) begin
      if (cmd_pop) begin
         is_rd    <= (cmd_head.op == mem_pkg::MEM_OP_RD_PRE);
         word_adr <= cmd_head.addr[`MEM_ADDR_W-1:2];   // drop byte offset
         remain   <= cmd_head.blen;
      end else if (step) begin
         word_adr <= word_adr + 1'b1;
         remain   <= remain - 1'b1;
      end
   end

   // array write under byte selects
   always_ff @(posedge wb_clk) begin
      if (wr_pop) begin
         for (int b = 0; b < SEL_W; b++) begin
            if (wr_head.sel[b]) mem_arr[word_adr][8*b +: 8] <= wr_head.data[8*b +: 8];
         end
      end
   end

endmodule

/* verilog/mem_top.sv */
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_top (
   input  logic                   wb_clk,
   input  logic                   mem_rst,
   input  logic                   wbm_cyc_i,
   input  logic                   wbm_stb_i,
   input  logic                   wbm_we_i,
   input  logic [`MEM_SEL_W-1:0]  wbm_sel_i,
   input  logic [`MEM_ADDR_W-1:0] wbm_addr_i,
   input  logic [`MEM_DATA_W-1:0] wbm_dat_i,
   output logic                   wbm_ack_o,
   output logic                   wbm_stall_o,
   output logic [`MEM_DATA_W-1:0] wbm_dat_o
);

   //////////////////////////////
   // controller to port fifos
   //////////////////////////////
   logic                   cmd_push;
   mem_pkg::mem_cmd_t      cmd;
   logic                   cmd_full;
   logic                   wr_push;
   mem_pkg::mem_wr_word_t  wr_word;
   logic                   wr_full;
   logic                   rd_pop;
   logic [`MEM_DATA_W-1:0] rd_data;
   logic                   rd_empty;

   wb_port_ctrl wb_port_ctrl_i (
      .wb_clk(wb_clk), .mem_rst(mem_rst),
      .wbm_cyc_i(wbm_cyc_i), .wbm_stb_i(wbm_stb_i), .wbm_we_i(wbm_we_i),
      .wbm_sel_i(wbm_sel_i), .wbm_addr_i(wbm_addr_i), .wbm_dat_i(wbm_dat_i),
      .wbm_ack_o(wbm_ack_o), .wbm_stall_o(wbm_stall_o), .wbm_dat_o(wbm_dat_o),
      .cmd_push_o(cmd_push), .cmd_o(cmd), .cmd_full_i(cmd_full),
      .wr_push_o(wr_push), .wr_word_o(wr_word), .wr_full_i(wr_full),
      .rd_pop_o(rd_pop), .rd_data_i(rd_data), .rd_empty_i(rd_empty)
   );

   // memory port with on-chip array
   mem_port mem_port_i (
      .wb_clk(wb_clk), .mem_rst(mem_rst),
      .cmd_push_i(cmd_push), .cmd_i(cmd), .cmd_full_o(cmd_full),
      .wr_push_i(wr_push), .wr_word_i(wr_word), .wr_full_o(wr_full),
      .rd_pop_i(rd_pop), .rd_data_o(rd_data), .rd_empty_o(rd_empty)
   );

endmodule

/* bench/mem_asserts.sv */
`timescale 1ns/100ps

module mem_asserts (
   input logic wb_clk,
   input logic mem_rst,
   input logic wbm_cyc_i,
   input logic wbm_ack_o,
   input logic wbm_stall_o,
   input logic wr_full_i,    // write data fifo full
   input logic cmd_full_i    // command fifo full
);

   int fail_cnt = 0;   // properties that failed so far

   //////////////////////////////
   // wishbone side
   //////////////////////////////

   // an ack belongs to a cycle that was open one clock earlier
   ack_in_cycle: assert property (@(posedge wb_clk) disable iff (mem_rst)
      wbm_ack_o |-> $past(wbm_cyc_i))
      else begin
         fail_cnt++;
         $error("ack with cyc low in the previous clock");
      end

   ack_after_reset: assert property (@(posedge wb_clk)
      $past(mem_rst) |-> !wbm_ack_o)
      else begin
         fail_cnt++;
         $error("ack high in the clock after reset");
      end

   // stall only comes from the fifo full flags
   stall_from_full: assert property (@(posedge wb_clk) disable iff (mem_rst)
      (!wr_full_i && !cmd_full_i) |-> !wbm_stall_o)
      else begin
         fail_cnt++;
         $error("stall high with both fifos not full");
      end

endmodule

bind mem_top mem_asserts mem_asserts_i (
   .wb_clk(wb_clk), .mem_rst(mem_rst), .wbm_cyc_i(wbm_cyc_i),
   .wbm_ack_o(wbm_ack_o), .wbm_stall_o(wbm_stall_o),
   .wr_full_i(wr_full), .cmd_full_i(cmd_full)
);

/* bench/mem_tb.sv */
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_tb;

   localparam int WORDS   = 2 ** `MEM_WORD_AW;   // words in the array
   localparam int ADDR_W  = `MEM_ADDR_W;
   localparam int MAX_OUT = 16;                   // strobes allowed ahead of their acks
   localparam int SEED    = 44;

   logic                   wb_clk;
   logic                   mem_rst;
   logic                   wbm_cyc_i;
   logic                   wbm_stb_i;
   logic                   wbm_we_i;
   logic [`MEM_SEL_W-1:0]  wbm_sel_i;
   logic [ADDR_W-1:0]      wbm_addr_i;
   logic [`MEM_DATA_W-1:0] wbm_dat_i;
   logic                   wbm_ack_o;
   logic                   wbm_stall_o;
   logic [`MEM_DATA_W-1:0] wbm_dat_o;

   logic [`MEM_DATA_W-1:0] model [WORDS];     // reference copy of the array
   logic [`MEM_DATA_W-1:0] blk_dat [WORDS];   // payload of the next write block
   logic [`MEM_SEL_W-1:0]  blk_sel [WORDS];
   integer                 seed;
   int                     err_cnt;
   int                     stb_total;         // strobes taken by the slave
   int                     ack_total;
   bit                     timed_out;
   bit                     stall_seen;        // slave pushed back at least once

   mem_top mem_top_i (.*);

   // 20 ns clock
   initial wb_clk = 1'b0;
   always #10 wb_clk = ~wb_clk;

   // totals sampled at the falling edge, bus is settled there
   always @(negedge wb_clk) begin
      if (!mem_rst) begin
         if (wbm_cyc_i && wbm_stb_i && !wbm_stall_o) stb_total++;
         if (wbm_ack_o) ack_total++;
         if (wbm_cyc_i && wbm_stb_i && wbm_stall_o) stall_seen = 1'b1;
      end
   end

   //////////////////////////////
   // bus master helpers
   //////////////////////////////
   function automatic int rand_word();
      return {$random(seed)} % WORDS;
   endfunction

   task automatic make_block_data(input int n, input bit rand_sel);
      for (int i = 0; i < n; i++) begin
         blk_dat[i] = $random(seed);
         blk_sel[i] = rand_sel ? `MEM_SEL_W'($random(seed)) : '1;   // all bytes unless random
      end
   endtask

   // cyc low, no ack may show up
   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge wb_clk);
         assert (!wbm_ack_o) else begin
            err_cnt++;
            $display("[FAIL] %0t wbm_ack_o got %b expected 0 with cyc low",
                     $time, wbm_ack_o);
         end
         @(posedge wb_clk);
         #2;
      end
   endtask

   // one pipelined cycle over n sequential words from word w0
   task automatic run_block(input bit we, input int w0, input int n);
      int issued;
      int acked;
      int cycles;
      int idx;
      issued    = 0;
      acked     = 0;
      cycles    = 0;
      wbm_cyc_i = 1'b1;
      wbm_we_i  = we;
      while (acked < n && !timed_out) begin
         wbm_stb_i  = (issued < n) && (issued - acked < MAX_OUT);
         wbm_addr_i = ADDR_W'((w0 + issued) * 4);   // byte address, wraps like the array
         wbm_sel_i  = we ? blk_sel[issued % WORDS] : '1;
         wbm_dat_i  = blk_dat[issued % WORDS];
         @(negedge wb_clk);
         if (wbm_ack_o) begin
            idx = (w0 + acked) % WORDS;
            if (!we) begin
               assert (wbm_dat_o === model[idx]) else begin
                  err_cnt++;
                  $display("[FAIL] %0t wbm_dat_o word %0d got %h expected %h",
                           $time, idx, wbm_dat_o, model[idx]);
               end
            end
            acked++;
         end
         if (wbm_stb_i && !wbm_stall_o) begin   // taken at the coming edge
            idx = (w0 + issued) % WORDS;
            if (we) begin
               for (int b = 0; b < `MEM_SEL_W; b++) begin
                  if (wbm_sel_i[b]) model[idx][8*b +: 8] = wbm_dat_i[8*b +: 8];
               end
            end
            issued++;
         end
         @(posedge wb_clk);
         #2;
         cycles++;
         if (cycles > 8 * n + 200) begin
            timed_out = 1'b1;
            err_cnt++;
            $display("timeout at %0t, block at word %0d got %0d of %0d acks",
                     $time, w0, acked, n);
         end
      end
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      wbm_we_i  = 1'b0;
   endtask

   //////////////////////////////
   // test sequence
   //////////////////////////////
   initial begin
      int w;
      int n;
      int prop_fails;
      seed       = SEED;
      err_cnt    = 0;
      stb_total  = 0;
      ack_total  = 0;
      timed_out  = 1'b0;
      stall_seen = 1'b0;
      mem_rst    = 1'b1;
      wbm_cyc_i  = 1'b0;
      wbm_stb_i  = 1'b0;
      wbm_we_i   = 1'b0;
      wbm_sel_i  = '0;
      wbm_addr_i = '0;
      wbm_dat_i  = '0;
      repeat (8) @(posedge wb_clk);
      #2;
      mem_rst = 1'b0;
      idle_cycles(10);   // quiet bus right after reset

      // single writes, each read back on its own
      for (int i = 0; i < 6 && !timed_out; i++) begin
         w = rand_word();
         make_block_data(1, 1'b0);
         run_block(1'b1, w, 1);
         idle_cycles(2);
         run_block(1'b0, w, 1);
         idle_cycles(2);
      end

      // whole array in one cycle, far beyond the write fifo
      stall_seen = 1'b0;
      make_block_data(WORDS, 1'b0);
      run_block(1'b1, 0, WORDS);
      assert (stall_seen) else begin
         err_cnt++;
         $display("wbm_stall_o never went high during the %0d word write", WORDS);
      end
      idle_cycles(4);

      // block write and read back, random selects in the second half
      for (int i = 0; i < 24 && !timed_out; i++) begin
         w = rand_word();
         n = 1 + {$random(seed)} % 16;
         make_block_data(n, i >= 12);
         run_block(1'b1, w, n);
         idle_cycles(1 + {$random(seed)} % 4);
         run_block(1'b0, w, n);
         idle_cycles(1 + {$random(seed)} % 4);
      end

      // read-ahead hits, then a read once the lifetime ran out
      for (int i = 0; i < 4 && !timed_out; i++) begin
         w = rand_word();
         run_block(1'b0, w, 1);
         idle_cycles(3);
         run_block(1'b0, w + 1, 1);
         idle_cycles(5);
         run_block(1'b0, w + 2, 2);
         idle_cycles(`MEM_INV_TIME + 10);
         run_block(1'b0, w + 4, 1);
         idle_cycles(3);
      end

      // overwrite the next read-ahead word, read must see the new value
      for (int i = 0; i < 4 && !timed_out; i++) begin
         w = rand_word();
         run_block(1'b0, w, 1);
         idle_cycles(2);
         make_block_data(1, 1'b0);
         run_block(1'b1, w + 1, 1);
         idle_cycles(2);
         run_block(1'b0, w + 1, 1);
         idle_cycles(2);
      end

      idle_cycles(10);
      assert (stb_total == ack_total) else begin
         err_cnt++;
         $display("[FAIL] %0t wbm_ack_o count got %0d expected %0d",
                  $time, ack_total, stb_total);
      end
      prop_fails = mem_top_i.mem_asserts_i.fail_cnt;
      $display("errors %0d, property failures %0d, strobes %0d, acks %0d, timeouts %0d",
               err_cnt, prop_fails, stb_total, ack_total, timed_out);
      if (err_cnt == 0 && prop_fails == 0 && !timed_out) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+common
common/mem_pkg.sv
verilog/sync_fifo.sv
wb_port/wb_port_ctrl.sv
mem_port/mem_port.sv
verilog/mem_top.sv
bench/mem_asserts.sv
bench/mem_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mem_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
